// File: build.f
src/eboxPkg.sv
src/cramStore.sv
src/microSequencer.sv
src/microDecode.sv
src/edpDatapath.sv
src/ebusDriver.sv
src/ebox.sv
tests/tbClock.sv
tests/ebox_asserts.sv
tests/eboxTb.sv

// File: tests/eboxTb.sv
`timescale 1ns/10ps
`default_nettype none

module eboxTb;

  localparam int haltSlack = 20; // Cycles past the program length before giving up

  logic                eboxClk;
  logic                arstN;
  logic                start;
  eboxPkg::cramAdr_t   startAdr;
  eboxPkg::word_t      ebusIn;
  logic                cramWrEn;
  eboxPkg::cramAdr_t   cramWrAdr;
  eboxPkg::microWord_t cramWrData;
  eboxPkg::word_t      ebusData;
  logic                edpDrivingEbus;
  logic                running;
  logic                halted;

  // Reference model state
  eboxPkg::microWord_t modelCram [eboxPkg::cramDepth];
  eboxPkg::word_t      modelAr;
  eboxPkg::word_t      modelBr;
  eboxPkg::cramAdr_t   progAdr [$];   // Program words in execution order
  eboxPkg::word_t      driveSeen [$]; // EBUS values of the last run
  eboxPkg::word_t      ebusUsed [$];  // ebusIn at each executing edge

  int checkCount;
  int errorCount;
  int testErrStart;
  int testsPassed;
  int testsFailed;

  tbClock clkGen (
    .eboxClk (eboxClk),
    .arstN   (arstN)
  );

  ebox uut (
    .eboxClk        (eboxClk),
    .arstN          (arstN),
    .start          (start),
    .startAdr       (startAdr),
    .ebusIn         (ebusIn),
    .cramWrEn       (cramWrEn),
    .cramWrAdr      (cramWrAdr),
    .cramWrData     (cramWrData),
    .ebusData       (ebusData),
    .edpDrivingEbus (edpDrivingEbus),
    .running        (running),
    .halted         (halted)
  );

  function automatic eboxPkg::word_t randWord();
    return eboxPkg::word_t'({$urandom(), $urandom()});
  endfunction

  function automatic eboxPkg::microWord_t randMicroWord();
    eboxPkg::microWord_t w;
    w.j         = eboxPkg::cramAdr_t'($urandom());
    w.ad        = eboxPkg::adFunc_t'($urandom() % 8);
    w.arSel     = eboxPkg::arSel_t'($urandom() % 4);
    w.brLoad    = 1'($urandom() % 2);
    w.ebusDrive = 1'($urandom() % 2);
    w.halt      = 1'($urandom() % 2);
    w.magic     = eboxPkg::magic_t'($urandom());
    return w;
  endfunction

  // AD result as the machine defines it, modulo 2^36
  function automatic eboxPkg::word_t modelAd(eboxPkg::adFunc_t f, eboxPkg::word_t a,
                                             eboxPkg::word_t b);
    case (f)
      eboxPkg::adAplusB:  return a + b;
      eboxPkg::adAminusB: return a - b;
      eboxPkg::adAandB:   return a & b;
      eboxPkg::adAorB:    return a | b;
      eboxPkg::adAxorB:   return a ^ b;
      eboxPkg::adB:       return b;
      eboxPkg::adAplus1:  return a + 1;
      default:            return a;
    endcase
  endfunction

  task automatic nextCycle();
    @(posedge eboxClk);
    #1; // Outputs settled, inputs change here
  endtask

  task automatic checkValue(string name, eboxPkg::word_t got, eboxPkg::word_t exp);
    checkCount++;
    assert (got === exp) else begin
      $display("[ERROR] %s: got %0h, expected %0h at %0t", name, got, exp, $time);
      errorCount++;
    end
  endtask

  task automatic writeWord(eboxPkg::cramAdr_t adr, eboxPkg::microWord_t w);
    cramWrEn   = 1'b1;
    cramWrAdr  = adr;
    cramWrData = w;
    nextCycle();
    cramWrEn       = 1'b0;
    modelCram[adr] = w;
  endtask

  // Chain of n words at distinct random addresses, halt on the last
  task automatic buildProgram(int n);
    bit                  used [eboxPkg::cramDepth];
    eboxPkg::cramAdr_t   adr;
    eboxPkg::microWord_t w;
    progAdr.delete();
    for (int i = 0; i < n; i++) begin
      do begin
        adr = eboxPkg::cramAdr_t'($urandom());
      end while (used[adr]);
      used[adr] = 1'b1;
      progAdr.push_back(adr);
    end
    for (int i = 0; i < n; i++) begin
      w      = randMicroWord();
      w.halt = (i == n - 1);
      if (i < n - 1) begin
        w.j = progAdr[i + 1];
      end
      writeWord(progAdr[i], w);
    end
  endtask

  // pokeMode 1 pulses start mid-run, 2 writes the control store every cycle
  task automatic runProgram(int pokeMode);
    int                  n;
    int                  cycles;
    int                  pokeStep;
    eboxPkg::cramAdr_t   pc;
    eboxPkg::microWord_t w;
    eboxPkg::word_t      expAd;
    eboxPkg::word_t      oldAr;
    n        = progAdr.size();
    pokeStep = $urandom() % n;
    pc       = progAdr[0];
    driveSeen.delete();
    ebusUsed.delete();
    start    = 1'b1;
    startAdr = pc;
    ebusIn   = randWord();
    nextCycle(); // Start edge
    start = 1'b0;
    checkValue("running", running, 1);
    cycles = 0;
    while (!halted && cycles < n + haltSlack) begin
      ebusIn = randWord();
      if (pokeMode == 1 && cycles == pokeStep) begin
        start    = 1'b1;
        startAdr = eboxPkg::cramAdr_t'($urandom());
      end
      if (pokeMode == 2) begin
        cramWrEn   = 1'b1;
        cramWrAdr  = progAdr[$urandom() % n];
        cramWrData = randMicroWord();
      end
      w     = modelCram[pc];
      expAd = modelAd(w.ad, modelAr, modelBr);
      oldAr = modelAr;
      case (w.arSel)
        eboxPkg::arAd:    modelAr = expAd;
        eboxPkg::arEbus:  modelAr = ebusIn;
        eboxPkg::arMagic: modelAr = eboxPkg::word_t'(w.magic);
        default:          modelAr = oldAr;
      endcase
      if (w.brLoad) begin
        modelBr = oldAr;
      end
      ebusUsed.push_back(ebusIn);
      pc = w.j;
      nextCycle();
      cycles++;
      start    = 1'b0;
      cramWrEn = 1'b0;
      checkValue("edpDrivingEbus", edpDrivingEbus, w.ebusDrive);
      if (edpDrivingEbus) begin
        driveSeen.push_back(ebusData);
      end
      if (w.ebusDrive) begin
        checkValue("ebusData", ebusData, expAd);
      end
      checkValue("running", running, !w.halt);
      checkValue("halted", halted, w.halt);
    end
    checkCount++;
    assert (halted) else begin
      $display("Timeout: halted did not rise within %0d cycles of start", n + haltSlack);
      errorCount++;
    end
    if (halted) begin
      checkValue("haltCycles", cycles, n);
    end
  endtask

  task automatic endTest(string name);
    if (errorCount == testErrStart) begin
      $display("%s: passed", name);
      testsPassed++;
    end else begin
      $display("%s: failed with %0d errors", name, errorCount - testErrStart);
      testsFailed++;
    end
    testErrStart = errorCount;
  endtask

  initial begin
    int                  waited;
    int                  failTotal;
    int                  lens [4];
    eboxPkg::microWord_t w;
    void'($urandom(51));
    start        = 1'b0;
    startAdr     = '0;
    ebusIn       = '0;
    cramWrEn     = 1'b0;
    cramWrAdr    = '0;
    cramWrData   = '0;
    modelAr      = '0;
    modelBr      = '0;
    checkCount   = 0;
    errorCount   = 0;
    testErrStart = 0;
    testsPassed  = 0;
    testsFailed  = 0;
    lens         = '{1, 2, 7, 16};

    waited = 0;
    while (arstN !== 1'b1 && waited < 10) begin
      nextCycle();
      waited++;
    end
    checkCount++;
    assert (arstN === 1'b1) else begin
      $display("Reset was never released");
      errorCount++;
    end
    checkValue("running", running, 0);
    checkValue("halted", halted, 0);
    checkValue("edpDrivingEbus", edpDrivingEbus, 0);
    checkValue("ebusData", ebusData, 0);
    endTest("resetState");

    for (int p = 0; p < 20; p++) begin
      buildProgram(1 + $urandom() % 12);
      runProgram(0);
      nextCycle();
    end
    endTest("randomPrograms");

    foreach (lens[i]) begin
      buildProgram(lens[i]);
      runProgram(0);
      nextCycle();
    end
    endTest("haltTiming");

    for (int p = 0; p < 6; p++) begin
      buildProgram(2 + $urandom() % 10);
      runProgram(1);
      nextCycle();
    end
    endTest("startWhileRunning");

    for (int p = 0; p < 6; p++) begin
      buildProgram(2 + $urandom() % 10);
      runProgram(2);
      runProgram(0); // Same program, store must be untouched
      nextCycle();
    end
    endTest("writeWhileRunning");

    // Load AR from EBUS, then drive it back out unchanged
    progAdr.delete();
    progAdr.push_back(eboxPkg::cramAdr_t'(8'hF0));
    progAdr.push_back(eboxPkg::cramAdr_t'(8'h3C));
    w           = randMicroWord();
    w.j         = progAdr[1];
    w.arSel     = eboxPkg::arEbus;
    w.ebusDrive = 1'b0;
    w.halt      = 1'b0;
    writeWord(progAdr[0], w);
    w           = randMicroWord();
    w.ad        = eboxPkg::adA;
    w.arSel     = eboxPkg::arHold;
    w.ebusDrive = 1'b1;
    w.halt      = 1'b1;
    writeWord(progAdr[1], w);
    runProgram(0);
    checkValue("driveCount", driveSeen.size(), 1);
    if (driveSeen.size() == 1) begin
      checkValue("ebusData", driveSeen[0], ebusUsed[0]);
    end
    endTest("ebusLoad");

    failTotal = errorCount + uut.eboxChecks.failCount;
    $display("Summary: %0d tests passed, %0d failed, %0d checks, %0d errors, %0d assertion fails",
             testsPassed, testsFailed, checkCount, errorCount, uut.eboxChecks.failCount);
    if (failTotal == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule : eboxTb

`default_nettype wire

// File: tests/ebox_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module ebox_asserts (
  input wire eboxClk,
  input wire arstN,
  input wire running,
  input wire halted,
  input wire edpDrivingEbus
);

  int failCount = 0; // Failed assertions so far

  // A drive strobe can only follow a cycle that executed a word
  driveAfterRun: assert property (@(posedge eboxClk) disable iff (!arstN)
      edpDrivingEbus |-> $past(running))
    else begin
      failCount++;
      $error("edpDrivingEbus high after a cycle with running low");
    end

  runHaltExclusive: assert property (@(posedge eboxClk) disable iff (!arstN)
      !(running && halted))
    else begin
      failCount++;
      $error("running and halted high together");
    end

  idleAfterReset: assert property (@(posedge eboxClk) $rose(arstN) |-> !running)
    else begin
      failCount++;
      $error("running high right after reset release");
    end

endmodule : ebox_asserts

bind ebox ebox_asserts eboxChecks (
  .eboxClk        (eboxClk),
  .arstN          (arstN),
  .running        (running),
  .halted         (halted),
  .edpDrivingEbus (edpDrivingEbus)
);

`default_nettype wire

// File: tests/tbClock.sv
`timescale 1ns/10ps
`default_nettype none

module tbClock (
  output logic eboxClk,
  output logic arstN
);

  initial begin
    eboxClk = 1'b0;
    forever begin
      #5 eboxClk = ~eboxClk; // 10 ns period
    end
  end

  // Reset held over the first three clock periods
  initial begin
    arstN = 1'b0;
    repeat (3) @(posedge eboxClk);
    @(negedge eboxClk);
    arstN = 1'b1;          // Released away from the rising edge
  end

endmodule : tbClock

`default_nettype wire

// File: src/ebox.sv
`timescale 1ns/10ps
`default_nettype none

module ebox (
  input  wire                      eboxClk,
  input  wire                      arstN,
  input  wire                      start,
  input  wire eboxPkg::cramAdr_t   startAdr,
  input  wire eboxPkg::word_t      ebusIn,
  input  wire                      cramWrEn,
  input  wire eboxPkg::cramAdr_t   cramWrAdr,
  input  wire eboxPkg::microWord_t cramWrData,
  output wire eboxPkg::word_t      ebusData,
  output wire                      edpDrivingEbus,
  output wire                      running,
  output wire                      halted
);

  eboxPkg::cramAdr_t   crAdr;
  eboxPkg::microWord_t cramWord; // Current microword
  eboxPkg::edpCtl_t    edpCtl;
  eboxPkg::word_t      adOut;

  cramStore crm0 (
    .eboxClk    (eboxClk),
    .cramWrEn   (cramWrEn),
    .cramWrAdr  (cramWrAdr),
    .cramWrData (cramWrData),
    .running    (running),
    .crAdr      (crAdr),
    .cramWord   (cramWord)
  );

  microSequencer cra0 (
    .eboxClk  (eboxClk),
    .arstN    (arstN),
    .start    (start),
    .startAdr (startAdr),
    .cramWord (cramWord),
    .crAdr    (crAdr),
    .running  (running),
    .halted   (halted)
  );

  microDecode dec0 (
    .cramWord (cramWord),
    .running  (running),
    .edpCtl   (edpCtl)
  );

  edpDatapath edp0 (
    .eboxClk (eboxClk),
    .arstN   (arstN),
    .edpCtl  (edpCtl),
    .ebusIn  (ebusIn),
    .adOut   (adOut)
  );

  // EDP transmitter onto EBUS
  ebusDriver ebus0 (
    .eboxClk        (eboxClk),
    .arstN          (arstN),
    .edpCtl         (edpCtl),
    .adOut          (adOut),
    .ebusData       (ebusData),
    .edpDrivingEbus (edpDrivingEbus)
  );

endmodule : ebox

`default_nettype wire

// File: src/ebusDriver.sv
`timescale 1ns/10ps
`default_nettype none

module ebusDriver (
  input  wire                   eboxClk,
  input  wire                   arstN,
  input  wire eboxPkg::edpCtl_t edpCtl,
  input  wire eboxPkg::word_t   adOut,
  output eboxPkg::word_t        ebusData,
  output logic                  edpDrivingEbus
);

  always_ff @(posedge eboxClk or negedge arstN) begin
    if (!arstN) begin
      ebusData       <= '0;
      edpDrivingEbus <= 1'b0;
    end else begin
      edpDrivingEbus <= edpCtl.ebusDrive; // High for one cycle per drive word
      if (edpCtl.ebusDrive) begin
        ebusData <= adOut;                // Holds between drive words
      end
    end
  end

endmodule : ebusDriver

`default_nettype wire

// File: src/edpDatapath.sv
`timescale 1ns/10ps
`default_nettype none

module edpDatapath (
  input  wire                   eboxClk,
  input  wire                   arstN,
  input  wire eboxPkg::edpCtl_t edpCtl,
  input  wire eboxPkg::word_t   ebusIn,
  output eboxPkg::word_t        adOut
);

  eboxPkg::word_t ar;
  eboxPkg::word_t br;
  eboxPkg::word_t magicExt;
  eboxPkg::word_t arNext;

  assign magicExt = {{(eboxPkg::wordWidth - eboxPkg::magicWidth){1'b0}}, edpCtl.magic};

  // AD function unit, all sums wrap at the word width
  always_comb begin
    adOut = ar;
    case (edpCtl.ad)
      eboxPkg::adA:       adOut = ar;
      eboxPkg::adAplusB:  adOut = ar + br;
      eboxPkg::adAminusB: adOut = ar - br;
      eboxPkg::adAandB:   adOut = ar & br;
      eboxPkg::adAorB:    adOut = ar | br;
      eboxPkg::adAxorB:   adOut = ar ^ br;
      eboxPkg::adB:       adOut = br;
      eboxPkg::adAplus1:  adOut = ar + eboxPkg::wordWidth'(1);
      default:            adOut = ar;
    endcase
  end

  // AR source mux
  always_comb begin
    case (edpCtl.arSel)
      eboxPkg::arAd:    arNext = adOut;
      eboxPkg::arEbus:  arNext = ebusIn;
      eboxPkg::arMagic: arNext = magicExt;
      default:          arNext = ar;      // arHold
    endcase
  end

  always_ff @(posedge eboxClk or negedge arstN) begin
    if (!arstN) begin
      ar <= '0;
      br <= '0;
    end else begin
      ar <= arNext;
      if (edpCtl.brLoad) begin
        br <= ar;                         // Old AR, same edge as AR load
      end
    end
  end

endmodule : edpDatapath

`default_nettype wire

// File: src/microDecode.sv
`timescale 1ns/10ps
`default_nettype none

module microDecode (
  input  wire eboxPkg::microWord_t cramWord,
  input  wire                      running,
  output eboxPkg::edpCtl_t         edpCtl
);

  // Only the register loads and the EBUS strobe need gating, the AD
  // function and magic field have no side effects on their own
  always_comb begin
    edpCtl.ad    = cramWord.ad;
    edpCtl.magic = cramWord.magic;
    if (running) begin
      edpCtl.arSel     = cramWord.arSel;
      edpCtl.brLoad    = cramWord.brLoad;
      edpCtl.ebusDrive = cramWord.ebusDrive;
    end else begin
      edpCtl.arSel     = eboxPkg::arHold; // Idle machine changes nothing
      edpCtl.brLoad    = 1'b0;
      edpCtl.ebusDrive = 1'b0;
    end
  end

endmodule : microDecode

`default_nettype wire

// File: src/microSequencer.sv
`timescale 1ns/10ps
`default_nettype none

module microSequencer (
  input  wire                      eboxClk,
  input  wire                      arstN,
  input  wire                      start,
  input  wire eboxPkg::cramAdr_t   startAdr,
  input  wire eboxPkg::microWord_t cramWord,
  output eboxPkg::cramAdr_t        crAdr,
  output logic                     running,
  output logic                     halted
);

  eboxPkg::seqState_t state;
  eboxPkg::seqState_t stateNext;

  always_comb begin
    stateNext = state;
    case (state)
      eboxPkg::seqIdle: begin
        if (start) begin
          stateNext = eboxPkg::seqRun;
        end
      end
      eboxPkg::seqRun: begin
        if (cramWord.halt) begin
          stateNext = eboxPkg::seqIdle; // Halt word still executes this cycle
        end
      end
      default: stateNext = eboxPkg::seqIdle;
    endcase
  end

  always_ff @(posedge eboxClk or negedge arstN) begin
    if (!arstN) begin
      state  <= eboxPkg::seqIdle;
      crAdr  <= '0;
      halted <= 1'b0;
    end else begin
      state <= stateNext;
      if (state == eboxPkg::seqIdle) begin
        if (start) begin
          crAdr  <= startAdr; // Program entry point
          halted <= 1'b0;
        end
      end else begin
        crAdr <= cramWord.j;   // Follow the jump field
        if (cramWord.halt) begin
          halted <= 1'b1;      // Sticky until the next start
        end
      end
    end
  end

  assign running = (state == eboxPkg::seqRun);

endmodule : microSequencer

`default_nettype wire

// File: src/cramStore.sv
`timescale 1ns/10ps
`default_nettype none

module cramStore (
  input  wire                      eboxClk,
  input  wire                      cramWrEn,
  input  wire eboxPkg::cramAdr_t   cramWrAdr,
  input  wire eboxPkg::microWord_t cramWrData,
  input  wire                      running,
  input  wire eboxPkg::cramAdr_t   crAdr,
  output eboxPkg::microWord_t      cramWord
);

  eboxPkg::microWord_t cram [eboxPkg::cramDepth];

  // Loaded from outside only while the sequencer is stopped
  always_ff @(posedge eboxClk) begin
    if (cramWrEn && !running) begin
      cram[cramWrAdr] <= cramWrData;
    end
  end

  assign cramWord = cram[crAdr]; // Asynchronous read

endmodule : cramStore

`default_nettype wire

// File: src/eboxPkg.sv
`default_nettype none

package eboxPkg;

  localparam int wordWidth    = 36;  // Machine word
  localparam int cramAdrWidth = 8;
  localparam int cramDepth    = 256; // Control store words
  localparam int magicWidth   = 9;   // Microword magic number

  typedef logic [wordWidth-1:0]    word_t;
  typedef logic [cramAdrWidth-1:0] cramAdr_t;
  typedef logic [magicWidth-1:0]   magic_t;

  // AD function select, arithmetic wraps at 36 bits
  typedef enum logic [2:0] {
    adA,       // AR
    adAplusB,  // AR + BR
    adAminusB, // AR - BR
    adAandB,
    adAorB,
    adAxorB,
    adB,       // BR
    adAplus1   // AR + 1
  } adFunc_t;

  typedef enum logic [1:0] {
    arHold,
    arAd,
    arEbus,
    arMagic    // Magic field, zero-extended
  } arSel_t;

  typedef struct packed {
    cramAdr_t j;         // Next control-store address
    adFunc_t  ad;
    arSel_t   arSel;
    logic     brLoad;    // BR takes AR
    logic     ebusDrive; // Publish AD on EBUS
    logic     halt;
    magic_t   magic;
  } microWord_t;

  // Controls from the decoder to the data path and EBUS driver
  typedef struct packed {
    adFunc_t ad;
    arSel_t  arSel;
    logic    brLoad;
    logic    ebusDrive;
    magic_t  magic;
  } edpCtl_t;

  typedef enum logic {
    seqIdle,
    seqRun
  } seqState_t;

endpackage : eboxPkg

`default_nettype wire
